//--- Makefile
SRCS := $(shell cat sim.f)

obj_dir/Vtb_text_display: sim.f $(SRCS)
	verilator --binary --assert --top-module tb_text_display -f sim.f

run: obj_dir/Vtb_text_display
	out=$$(obj_dir/Vtb_text_display 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- glyph_line_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module glyph_line_buffer
    import vga_pkg::*;
#(
    parameter int TEXT_X = 258,
    parameter int TEXT_Y = 200
)
(
    input  logic clk_vga,
    input  logic rst_n,
    scan_if.sink scan,
    output logic glyph_on
);

    localparam int ROW_W = $clog2(GLYPH_H);

    // text box edges in active-area coordinates
    localparam pos_t BOX_X0 = pos_t'(TEXT_X);
    localparam pos_t BOX_X1 = pos_t'(TEXT_X + GLYPH_W);
    localparam pos_t BOX_Y0 = pos_t'(TEXT_Y);
    localparam pos_t BOX_Y1 = pos_t'(TEXT_Y + GLYPH_H);

    glyph_row_t       shift_q;
    glyph_row_t       row_next;
    logic [ROW_W-1:0] row_idx;
    logic             row_in_box;
    logic             col_in_box;
    logic             in_box;

    assign row_in_box = scan.active && (scan.y >= BOX_Y0) && (scan.y < BOX_Y1);
    assign col_in_box = (scan.x >= BOX_X0) && (scan.x < BOX_X1);
    assign in_box     = row_in_box && col_in_box;
    assign row_idx    = ROW_W'(scan.y - BOX_Y0);

    // fresh row at line start, otherwise keep shifting what is held
    assign row_next = (scan.line_start && row_in_box) ? GLYPH_BITMAP[row_idx] : shift_q;

    //////////////////////////////
    // row shifter
    always_ff @(posedge clk_vga)
    begin
        if (in_box)
        begin
            shift_q <= {row_next[GLYPH_W-2:0], 1'b0};   // next pixel to msb
        end
        else
        begin
            shift_q <= row_next;
        end
    end

    always_ff @(posedge clk_vga or negedge rst_n)
    begin
        if (!rst_n)
        begin
            glyph_on <= 1'b0;
        end
        else
        begin
            glyph_on <= in_box && row_next[GLYPH_W-1];
        end
    end

endmodule

`default_nettype wire

//--- pixel_shader.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_shader
    import vga_pkg::*;
(
    input  logic clk_vga,
    input  logic rst_n,
    scan_if.sink scan,
    input  logic glyph_on,
    input  rgb_t fg_color,
    input  rgb_t bg_color,
    output logic hsync,
    output logic vsync,
    output rgb_t rgb
);

    logic active_d;
    logic hsync_d;
    logic vsync_d;
    rgb_t fg_q;
    rgb_t bg_q;
    rgb_t pix_next;
    logic frame_start;

    assign frame_start = vsync_d && !scan.vsync;   // delayed vsync about to fall

    always_comb
    begin
        if (!active_d)
            pix_next = RGB_BLACK;   // porch and sync
        else if (glyph_on)
            pix_next = fg_q;
        else
            pix_next = bg_q;
    end

    //////////////////////////////
    // stage 1 lines up with glyph_on
    always_ff @(posedge clk_vga or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
            fg_q     <= RGB_BLACK;
            bg_q     <= RGB_BLACK;
        end
        else
        begin
            active_d <= scan.active;
            hsync_d  <= scan.hsync;
            vsync_d  <= scan.vsync;
            if (frame_start)
            begin
                fg_q <= fg_color;   // held for the next frame
                bg_q <= bg_color;
            end
        end
    end

    //////////////////////////////
    // stage 2, output registers
    always_ff @(posedge clk_vga or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            rgb   <= RGB_BLACK;
        end
        else
        begin
            hsync <= hsync_d;
            vsync <= vsync_d;
            rgb   <= pix_next;
        end
    end

endmodule

`default_nettype wire

//--- scan_if.sv
`timescale 1ns/100ps
`default_nettype none

// raster position and sync levels, one update per pixel
interface scan_if
    import vga_pkg::*;
();

    pos_t x;            // active-area column
    pos_t y;            // active-area row
    logic active;
    logic hsync;        // active low
    logic vsync;        // active low
    logic line_start;   // x == 0 on a visible line

    modport source (
        output x, y, active, hsync, vsync, line_start
    );

    modport sink (
        input x, y, active, hsync, vsync, line_start
    );

endinterface

`default_nettype wire

//--- sim.f
vga_pkg.sv
scan_if.sv
vga_timing.sv
glyph_line_buffer.sv
pixel_shader.sv
text_display_top.sv
text_display_props.sv
tb_text_display.sv

//--- tb_text_display.sv
`timescale 1ns/100ps
`default_nettype none

module tb_text_display
    import vga_pkg::*;
();

    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int H_ACTIVE = 160;
    localparam int H_FRONT  = 4;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int V_ACTIVE = 40;
    localparam int V_FRONT  = 2;
    localparam int TEXT_X   = 16;
    localparam int TEXT_Y   = 4;
    localparam int H_START  = H_SYNC + H_BACK;
    localparam int V_START  = V_SYNC + V_BACK;
    localparam int H_TOTAL  = H_START + H_ACTIVE + H_FRONT;
    localparam int WAIT_MAX = 2 * H_TOTAL * (V_START + V_ACTIVE + V_FRONT);   // two frames

    logic        clk_vga;
    logic        rst_n;
    logic [11:0] fg_color;
    logic [11:0] bg_color;
    logic        hsync;
    logic        vsync;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;
    rgb_t        out_rgb;

    // output raster position, -1 until the first sync edge
    int   h_pos    = -1;
    int   v_pos    = -1;
    int   hs_low   = 0;
    int   vs_lines = 0;
    logic hs_prev  = 1'b1;
    logic vs_prev  = 1'b1;
    rgb_t frame_fg = RGB_BLACK;   // colours the frame on screen should use
    rgb_t frame_bg = RGB_BLACK;

    text_display_top #(
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .TEXT_X   (TEXT_X),
        .TEXT_Y   (TEXT_Y)
    ) u_dut (
        .clk_vga  (clk_vga),
        .rst_n    (rst_n),
        .fg_color (fg_color),
        .bg_color (bg_color),
        .hsync    (hsync),
        .vsync    (vsync),
        .vga_r    (vga_r),
        .vga_g    (vga_g),
        .vga_b    (vga_b)
    );

    assign out_rgb = {vga_r, vga_g, vga_b};

    always #50 clk_vga = ~clk_vga;

    //////////////////////////////
    // checks
    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_level(input string name, input pos_t exp, input pos_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s: expected %0d, got %0d", name, exp, act);
            fail_run();
        end
    endtask

    function automatic bit in_active(input int h, input int v);
        return h >= H_START && h < H_START + H_ACTIVE && v >= V_START && v < V_START + V_ACTIVE;
    endfunction

    // box rule and bitmap, msb of a row is the left edge
    function automatic rgb_t expected_rgb(input int x, input int y);
        logic [4:0] row_i;
        logic [6:0] bit_i;
        row_i = 5'(y - TEXT_Y);
        bit_i = 7'(GLYPH_W - 1 - (x - TEXT_X));
        if (x >= TEXT_X && x < TEXT_X + GLYPH_W && y >= TEXT_Y && y < TEXT_Y + GLYPH_H)
        begin
            if (GLYPH_BITMAP[row_i][bit_i])
                return frame_fg;
        end
        return frame_bg;
    endfunction

    //////////////////////////////
    // raster tracking, one call per pixel
    task automatic step_pixel();
        @(negedge clk_vga);
        if (hs_prev && !hsync)
        begin
            if (h_pos >= 0)
                check_level("line length", pos_t'(H_TOTAL), pos_t'(h_pos + 1));
            h_pos = 0;
            if (vs_prev && !vsync)
            begin
                v_pos    = 0;
                frame_fg = fg_color;   // latched one cycle before
                frame_bg = bg_color;
            end
            else if (v_pos >= 0)
                v_pos++;
        end
        else if (h_pos >= 0)
            h_pos++;
        if (!hsync)
            hs_low++;
        else if (!hs_prev)
        begin
            check_level("hsync width", pos_t'(H_SYNC), pos_t'(hs_low));
            hs_low = 0;
        end
        if (!vsync)
        begin
            if (h_pos == 0)
                vs_lines++;
        end
        else if (!vs_prev)
        begin
            check_level("vsync width", pos_t'(V_SYNC), pos_t'(vs_lines));
            vs_lines = 0;
        end
        if (v_pos >= 0 && !in_active(h_pos, v_pos))
            check_rgb("blanking", RGB_BLACK, out_rgb);
        hs_prev = hsync;
        vs_prev = vsync;
    endtask

    task automatic wait_pos(input int h, input int v, input string what);
        int n;
        n = 0;
        do
        begin
            step_pixel();
            n++;
        end
        while ((h_pos != h || v_pos != v) && n < WAIT_MAX);
        if (h_pos != h || v_pos != v)
        begin
            $display("Timed out waiting for %s.", what);
            fail_run();
        end
    endtask

    initial
    begin
        int          fd;
        int          n;
        int          x;
        int          y;
        int          cnt;
        logic [7:0]  kind;
        logic [11:0] c_fg;
        logic [11:0] c_bg;
        logic [11:0] exp_hex;
        logic [8*80-1:0] line_buf;
        bit          done;

        clk_vga  = 1'b0;
        rst_n    = 1'b0;
        fg_color = 12'h000;
        bg_color = 12'h000;
        void'($urandom(94));

        repeat (3) @(posedge clk_vga);
        rst_n <= 1'b1;
        @(negedge clk_vga);
        check_level("hsync after reset", pos_t'(1), pos_t'(hsync));
        check_level("vsync after reset", pos_t'(1), pos_t'(vsync));
        check_rgb("colour after reset", RGB_BLACK, out_rgb);
        wait_pos(0, 0, "the first frame");

        fd = $fopen("text_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open text_stimulus.txt.");
            fail_run();
        end
        done = 1'b0;
        while (!done)
        begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1)
                done = 1'b1;
            else if (kind == "#")
                n = $fgets(line_buf, fd);   // comment
            else if (kind == "c")
            begin
                n = $fscanf(fd, "%h %h", c_fg, c_bg);
                @(posedge clk_vga);
                fg_color <= c_fg;
                bg_color <= c_bg;
            end
            else if (kind == "s")
            begin
                n = $fscanf(fd, "%d %d %h", x, y, exp_hex);
                wait_pos(H_START + x, V_START + y, $sformatf("pixel %0d,%0d", x, y));
                check_rgb($sformatf("sample %0d,%0d", x, y), rgb_t'(exp_hex), out_rgb);
            end
            else if (kind == "r")
            begin
                n = $fscanf(fd, "%d", cnt);
                repeat (cnt)
                begin
                    x = $urandom_range(H_ACTIVE - 1);
                    y = $urandom_range(V_ACTIVE - 1);
                    wait_pos(H_START + x, V_START + y, $sformatf("pixel %0d,%0d", x, y));
                    check_rgb($sformatf("random %0d,%0d", x, y), expected_rgb(x, y), out_rgb);
                end
            end
            else
            begin
                $display("Unknown record type in the stimulus file.");
                fail_run();
            end
        end
        $fclose(fd);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- text_display_props.sv
`timescale 1ns/100ps
`default_nettype none

module text_display_props #(
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 46,
    parameter int H_ACTIVE = 640,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 31,
    parameter int V_ACTIVE = 480
)
(
    input logic       clk_vga,
    input logic       rst_n,
    input logic       hsync,
    input logic       vsync,
    input logic [3:0] vga_r,
    input logic [3:0] vga_g,
    input logic [3:0] vga_b
);

    int   h_reg;
    int   v_reg;
    int   h_now;       // output column of the sampled pixel
    int   v_now;
    int   hs_low;
    int   vs_lines;
    logic hs_q;
    logic vs_q;
    logic line_go;
    logic blank;

    assign line_go = hs_q && !hsync;
    assign h_now   = line_go ? 0 : h_reg + 1;
    assign v_now   = (vs_q && !vsync) ? 0 : (line_go ? v_reg + 1 : v_reg);
    assign blank   = h_now < H_SYNC + H_BACK || h_now >= H_SYNC + H_BACK + H_ACTIVE ||
                     v_now < V_SYNC + V_BACK || v_now >= V_SYNC + V_BACK + V_ACTIVE;

    always_ff @(posedge clk_vga or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hs_q     <= 1'b1;
            vs_q     <= 1'b1;
            h_reg    <= 0;
            v_reg    <= 0;
            hs_low   <= 0;
            vs_lines <= 0;
        end
        else
        begin
            hs_q     <= hsync;
            vs_q     <= vsync;
            h_reg    <= h_now;
            v_reg    <= v_now;
            hs_low   <= hsync ? 0 : hs_low + 1;
            vs_lines <= vsync ? 0 : vs_lines + (line_go ? 1 : 0);   // lines inside vsync
        end
    end

    a_hsync_width: assert property (@(posedge clk_vga) disable iff (!rst_n)
        $rose(hsync) |-> hs_low == H_SYNC)
        else $error("hsync was low for %0d cycles", hs_low);

    a_vsync_width: assert property (@(posedge clk_vga) disable iff (!rst_n)
        $rose(vsync) |-> vs_lines == V_SYNC)
        else $error("vsync was low for %0d lines", vs_lines);

    a_blank_black: assert property (@(posedge clk_vga) disable iff (!rst_n)
        blank |-> (vga_r == 4'h0 && vga_g == 4'h0 && vga_b == 4'h0))
        else $error("colour outside the active area at %0d,%0d", h_now, v_now);

endmodule

bind text_display_top text_display_props #(
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .H_ACTIVE (H_ACTIVE),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .V_ACTIVE (V_ACTIVE)
) u_props (
    .clk_vga (clk_vga),
    .rst_n   (rst_n),
    .hsync   (hsync),
    .vsync   (vsync),
    .vga_r   (vga_r),
    .vga_g   (vga_g),
    .vga_b   (vga_b)
);

`default_nettype wire

//--- text_display_top.sv
`timescale 1ns/100ps
`default_nettype none

module text_display_top
    import vga_pkg::*;
#(
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 46,
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 18,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 31,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 12,
    parameter int TEXT_X   = 258,
    parameter int TEXT_Y   = 200
)
(
    input  logic        clk_vga,
    input  logic        rst_n,
    input  logic [11:0] fg_color,
    input  logic [11:0] bg_color,
    output logic        hsync,
    output logic        vsync,
    output logic [3:0]  vga_r,
    output logic [3:0]  vga_g,
    output logic [3:0]  vga_b
);

    logic glyph_on;
    rgb_t pix_rgb;

    scan_if u_scan ();

    vga_timing #(
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT)
    ) u_timing (
        .clk_vga (clk_vga),
        .rst_n   (rst_n),
        .scan    (u_scan.source)
    );

    glyph_line_buffer #(
        .TEXT_X (TEXT_X),
        .TEXT_Y (TEXT_Y)
    ) u_glyph (
        .clk_vga  (clk_vga),
        .rst_n    (rst_n),
        .scan     (u_scan.sink),
        .glyph_on (glyph_on)
    );

    pixel_shader u_shader (
        .clk_vga  (clk_vga),
        .rst_n    (rst_n),
        .scan     (u_scan.sink),
        .glyph_on (glyph_on),
        .fg_color (fg_color),
        .bg_color (bg_color),
        .hsync    (hsync),
        .vsync    (vsync),
        .rgb      (pix_rgb)
    );

    // split into the connector channels
    assign vga_r = pix_rgb.r;
    assign vga_g = pix_rgb.g;
    assign vga_b = pix_rgb.b;

endmodule

`default_nettype wire

//--- text_stimulus.txt
# c fg bg     drive new frame colours in hex, shown from the next frame on
# s x y rgb   active pixel x,y must show rgb in hex
# r n         n random pixels, expected value from the glyph bitmap
s 0 0 000
c F80 024
s 16 4 000     # frame 0 still black
s 16 4 F80     # frame 1
s 48 4 024
s 49 4 F80
s 34 19 F80
s 35 19 024
c 0F4 300
s 116 19 F80   # same frame, old colours
s 136 35 F80
s 143 35 024
s 0 0 300      # frame 2
s 50 3 300
s 15 4 300
s 144 10 300
s 116 19 0F4
s 136 35 0F4
s 143 35 300
s 50 36 300
s 159 39 300
r 12

//--- vga_pkg.sv
`default_nettype none

package vga_pkg;

    typedef logic [9:0] pos_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    localparam rgb_t RGB_BLACK = '{r: 4'h0, g: 4'h0, b: 4'h0};

    localparam int GLYPH_W = 128;
    localparam int GLYPH_H = 32;

    typedef logic [GLYPH_W-1:0] glyph_row_t;

    //////////////////////////////
    // four characters, msb is the leftmost pixel
    localparam glyph_row_t GLYPH_BITMAP [GLYPH_H] = '{
        128'hFFFFFFC07FFC00001FFF0000007C0000,   // row 0, top
        128'hFFFFFFC07FFE00003FFF800000FE0000,
        128'hFFFFFFC07FFF00007FFFC00001CF0000,
        128'hFFFFFFC0783F8000FE0FE00001CF0000,
        128'hFFFFFFC0780FC001FC07F00003CF8000,
        128'hF80000007807E003F803F00003878000,
        128'hF80000007803F007F001F0000787C000,
        128'hF80000007801F007F00000000703C000,
        128'hF80000007800F007E00000000F03E000,
        128'hF80000007800F007C00000000E01E000,
        128'hF80000007800F007800000001E01F000,
        128'hF80000007801F0078FFFFF001C00F000,
        128'hF80000007803F0078FFFFF003C00F800,
        128'hF80000007807F0078FFFFF0038007800,
        128'hF8000000780FE0078FFFFF0078007C00,
        128'hFFFFE000781FC0078007C0007FFFFC00,
        128'hFFFFE000783F80078007C000FFFFFE00,
        128'hFFFFE0007FFF00078007C000FFFFFE00,
        128'hF80000007FFE00078007C001F8003F00,
        128'hF80000007FFC00078007C001F8003F00,
        128'hF8000000780000078007C003F8003F80,
        128'hF8000000780000078007C003F0001F80,
        128'hF800000078000007C00FC003E0000F80,
        128'hF800000078000007E01FC003C0000780,
        128'hF800000078000007F03FC003C0000780,
        128'hF800000078000007F87FC003C0000780,
        128'hF800000078000003FFFFC003C0000780,
        128'hF800000078000001FFFFC003C0000780,
        128'hF800000078000000FFFFC003C0000780,
        128'hF8000000780000007FFF8003C0000780,
        128'hF8000000780000003FFF0003C0000780,
        128'hF8000000780000001FFE0007F0001EC0    // row 31, bottom
    };

endpackage

`default_nettype wire

//--- vga_timing.sv
`timescale 1ns/100ps
`default_nettype none

module vga_timing
    import vga_pkg::*;
#(
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 46,
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 18,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 31,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 12
)
(
    input  logic   clk_vga,
    input  logic   rst_n,
    scan_if.source scan
);

    localparam int H_TOTAL = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;

    localparam pos_t H_START = pos_t'(H_SYNC + H_BACK);
    localparam pos_t H_END   = pos_t'(H_SYNC + H_BACK + H_ACTIVE);
    localparam pos_t V_START = pos_t'(V_SYNC + V_BACK);
    localparam pos_t V_END   = pos_t'(V_SYNC + V_BACK + V_ACTIVE);
    localparam pos_t H_LAST  = pos_t'(H_TOTAL - 1);
    localparam pos_t V_LAST  = pos_t'(V_TOTAL - 1);

    pos_t h_cnt;
    pos_t v_cnt;
    logic h_active;
    logic v_active;

    //////////////////////////////
    // raster counters
    always_ff @(posedge clk_vga or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == H_LAST)
        begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;   // frame wrap
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // decoded levels, no extra latency
    assign h_active = (h_cnt >= H_START) && (h_cnt < H_END);
    assign v_active = (v_cnt >= V_START) && (v_cnt < V_END);

    assign scan.hsync      = (h_cnt >= pos_t'(H_SYNC));   // low during sync
    assign scan.vsync      = (v_cnt >= pos_t'(V_SYNC));
    assign scan.active     = h_active && v_active;
    assign scan.x          = h_cnt - H_START;
    assign scan.y          = v_cnt - V_START;
    assign scan.line_start = v_active && (h_cnt == H_START);

endmodule

`default_nettype wire
